// ==== gn_num_pkg.sv ====
// numeric widths of the datapath and the lane map of the product array.
// ACC_W covers full-scale 16-bit products over at most 256 samples per frame.
package gn_num_pkg;

	// ****************************************
	// operand, product and sum widths
	// ****************************************
	localparam int DATA_W = 16; // signed jacobian and residual inputs.
	localparam int PROD_W = 2 * DATA_W; // full product without rounding.
	localparam int ACC_W = 40; // 32-bit products plus 8 bits of growth.

	// ****************************************
	// product lanes
	// ****************************************
	localparam int N_LANES = 9;

	// upper triangle of JtJ first, then Jtr
	typedef enum logic [3:0] {
		ln_j00, // j0*j0.
		ln_j01, // j0*j1.
		ln_j02, // j0*j2.
		ln_j11, // j1*j1.
		ln_j12, // j1*j2.
		ln_j22, // j2*j2.
		ln_r0, // j0*r.
		ln_r1, // j1*r.
		ln_r2 // j2*r.
	} lane_e;

endpackage

// ==== gn_ctrl_pkg.sv ====
// frame control constants for the sequencer.
// FRAME_LEN must stay between 1 and 256 to fit CNT_W and the accumulator headroom.
package gn_ctrl_pkg;

	// ****************************************
	// frame geometry
	// ****************************************
	localparam int FRAME_LEN = 16; // samples per frame.
	localparam int CNT_W = 8; // sample counter width.

	// ****************************************
	// sequencer states
	// ****************************************
	typedef enum logic {
		st_idle, // no frame open.
		st_frame // frame partly filled.
	} seq_state_e;

endpackage

// ==== prod_ifc.sv ====
// lane products from the multiplier to the accumulator with no handshake.
// first and last are only meaningful while prod_valid is high.
interface prod_ifc
	import gn_num_pkg::*;
();

	logic signed [PROD_W-1:0] prod [N_LANES]; // one product per lane_e entry.
	logic                     prod_valid; // lane set counts this cycle.
	logic                     prod_first; // first sample of a frame.
	logic                     prod_last; // last sample of a frame.

	// ****************************************
	// views
	// ****************************************
	modport src (
		output prod,
		output prod_valid,
		output prod_first,
		output prod_last
	);

	modport dst (
		input prod,
		input prod_valid,
		input prod_first,
		input prod_last
	);

endinterface

// ==== lane_mult.sv ====
// two-stage signed multiplier array with an input register and a product register.
// tags ride along with the data so frames may follow without a gap.
module lane_mult
	import gn_num_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic signed [DATA_W-1:0] op_a [N_LANES],
	input  logic signed [DATA_W-1:0] op_b [N_LANES],
	input  logic                     op_valid,
	input  logic                     op_first,
	input  logic                     op_last,
	prod_ifc.src                     p
);

	logic signed [DATA_W-1:0] a_q [N_LANES];
	logic signed [DATA_W-1:0] b_q [N_LANES];
	logic                     valid_q;
	logic                     first_q;
	logic                     last_q;

	// ****************************************
	// stage 1 operand register
	// ****************************************
	always_ff @(posedge clk) begin
		if (op_valid) begin
			a_q <= op_a;
			b_q <= op_b;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			valid_q <= op_valid;
			first_q <= op_first;
			last_q <= op_last;
		end
	end

	// ****************************************
	// stage 2 product register
	// ****************************************
	always_ff @(posedge clk) begin
		if (valid_q) begin
			for (int i = 0; i < N_LANES; i++) begin
				p.prod[i] <= PROD_W'(a_q[i]) * PROD_W'(b_q[i]); // exact with both sign-extended.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			p.prod_valid <= 1'b0;
			p.prod_first <= 1'b0;
			p.prod_last <= 1'b0;
		end else begin
			p.prod_valid <= valid_q;
			p.prod_first <= first_q;
			p.prod_last <= last_q;
		end
	end

endmodule

// ==== lane_accum.sv ====
// nine running sums; the first sample of a frame loads, later samples add.
// result_lanes is updated only on the last sample and holds until the next frame ends.
module lane_accum
	import gn_num_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	prod_ifc.dst                    p,
	output logic                    result_valid,
	output logic signed [ACC_W-1:0] result_lanes [N_LANES]
);

	logic signed [ACC_W-1:0] acc [N_LANES];
	logic signed [ACC_W-1:0] acc_nxt [N_LANES];
	logic                    frame_done;

	// ****************************************
	// next sums
	// ****************************************
	// a first-tagged set restarts the lane, so no clear cycle between frames
	always_comb begin
		for (int i = int'(ln_j00); i <= int'(ln_r2); i++) begin
			if (p.prod_first) begin
				acc_nxt[i] = ACC_W'(p.prod[i]); // sign-extended load.
			end else begin
				acc_nxt[i] = acc[i] + ACC_W'(p.prod[i]);
			end
		end
	end

	assign frame_done = p.prod_valid & p.prod_last;

	// ****************************************
	// accumulators
	// ****************************************
	always_ff @(posedge clk) begin
		if (p.prod_valid) begin
			acc <= acc_nxt; // bubbles leave sums alone.
		end
	end

	// ****************************************
	// published results
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= frame_done; // one-cycle pulse.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_LANES; i++) begin
				result_lanes[i] <= '0;
			end
		end else if (frame_done) begin
			result_lanes <= acc_nxt; // includes the last sample.
		end
	end

endmodule

// ==== frame_seq.sv ====
// takes one jacobian row and residual per sample_valid strobe with FRAME_LEN per frame.
// there is no back-pressure; low strobes are bubbles and leave the count untouched.
module frame_seq
	import gn_num_pkg::*;
	import gn_ctrl_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     sample_valid,
	input  logic signed [DATA_W-1:0] j0,
	input  logic signed [DATA_W-1:0] j1,
	input  logic signed [DATA_W-1:0] j2,
	input  logic signed [DATA_W-1:0] r,
	output logic signed [DATA_W-1:0] op_a [N_LANES],
	output logic signed [DATA_W-1:0] op_b [N_LANES],
	output logic                     op_valid,
	output logic                     op_first,
	output logic                     op_last,
	output logic                     frame_open
);

	seq_state_e               state;
	seq_state_e               state_nxt;
	logic [CNT_W-1:0]         cnt; // samples taken in the open frame.
	logic [CNT_W-1:0]         cnt_nxt;
	logic                     is_first;
	logic                     is_last;
	logic signed [DATA_W-1:0] pair_a [N_LANES];
	logic signed [DATA_W-1:0] pair_b [N_LANES];

	// ****************************************
	// frame tracking
	// ****************************************
	assign is_first = (state == st_idle); // count is zero here.
	assign is_last = (cnt == CNT_W'(FRAME_LEN - 1));

	always_comb begin
		state_nxt = state;
		cnt_nxt = cnt;
		case (state)
			st_idle: begin
				if (sample_valid && !is_last) begin
					state_nxt = st_frame; // single-sample frames stay idle.
					cnt_nxt = cnt + 1'b1;
				end
			end
			st_frame: begin
				if (sample_valid) begin
					if (is_last) begin
						state_nxt = st_idle;
						cnt_nxt = '0;
					end else begin
						cnt_nxt = cnt + 1'b1;
					end
				end
			end
			default: begin
				state_nxt = st_idle;
				cnt_nxt = '0;
			end
		endcase
	end

	assign frame_open = (state == st_frame);

	// ****************************************
	// operand pairing in lane order
	// ****************************************
	always_comb begin
		pair_a[ln_j00] = j0;
		pair_b[ln_j00] = j0;
		pair_a[ln_j01] = j0;
		pair_b[ln_j01] = j1;
		pair_a[ln_j02] = j0;
		pair_b[ln_j02] = j2;
		pair_a[ln_j11] = j1;
		pair_b[ln_j11] = j1;
		pair_a[ln_j12] = j1;
		pair_b[ln_j12] = j2;
		pair_a[ln_j22] = j2;
		pair_b[ln_j22] = j2;
		pair_a[ln_r0] = j0; // residual lanes.
		pair_b[ln_r0] = r;
		pair_a[ln_r1] = j1;
		pair_b[ln_r1] = r;
		pair_a[ln_r2] = j2;
		pair_b[ln_r2] = r;
	end

	// ****************************************
	// registers
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			cnt <= '0;
			op_valid <= 1'b0;
			op_first <= 1'b0;
			op_last <= 1'b0;
		end else begin
			state <= state_nxt;
			cnt <= cnt_nxt;
			op_valid <= sample_valid;
			op_first <= sample_valid & is_first;
			op_last <= sample_valid & is_last;
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			op_a <= pair_a;
			op_b <= pair_b;
		end
	end

endmodule

// ==== gn_normal_top.sv ====
// normal-equation builder for the JtJ upper triangle and Jtr of each frame.
// result_valid pulses 4 cycles after the last sample; result_lanes is indexed by lane_e.
module gn_normal_top
	import gn_num_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    sample_valid,
	input  logic signed [DATA_W-1:0] j0,
	input  logic signed [DATA_W-1:0] j1,
	input  logic signed [DATA_W-1:0] j2,
	input  logic signed [DATA_W-1:0] r,
	output logic                    result_valid,
	output logic signed [ACC_W-1:0] result_lanes [N_LANES],
	output logic                    frame_open
);

	logic signed [DATA_W-1:0] op_a [N_LANES];
	logic signed [DATA_W-1:0] op_b [N_LANES];
	logic                     op_valid;
	logic                     op_first;
	logic                     op_last;

	prod_ifc u_prod_ifc ();

	// ****************************************
	// sequencer, multiplier, accumulator
	// ****************************************
	frame_seq u_frame_seq (
		.clk          (clk),
		.rst          (rst),
		.sample_valid (sample_valid),
		.j0           (j0),
		.j1           (j1),
		.j2           (j2),
		.r            (r),
		.op_a         (op_a),
		.op_b         (op_b),
		.op_valid     (op_valid),
		.op_first     (op_first),
		.op_last      (op_last),
		.frame_open   (frame_open)
	);

	lane_mult u_lane_mult (
		.clk      (clk),
		.rst      (rst),
		.op_a     (op_a),
		.op_b     (op_b),
		.op_valid (op_valid),
		.op_first (op_first),
		.op_last  (op_last),
		.p        (u_prod_ifc.src)
	);

	lane_accum u_lane_accum (
		.clk          (clk),
		.rst          (rst),
		.p            (u_prod_ifc.dst),
		.result_valid (result_valid),
		.result_lanes (result_lanes)
	);

endmodule

// ==== tb_gn_normal.sv ====
// directed testbench for gn_normal_top with expected sums from a per-frame model.
// results are checked in order of frame completion; one run sends N_FRAMES frames.
module tb_gn_normal
	import gn_num_pkg::*;
	import gn_ctrl_pkg::*;
();

	localparam int N_FRAMES = 9; // frames sent over all tests.
	localparam int CYCLE_LIMIT = 20 * FRAME_LEN * N_FRAMES + 100;
	localparam int LATENCY = 3; // edges from the accepting edge to a visible result.
	localparam logic signed [DATA_W-1:0] MAX_V = 16'sh7fff;
	localparam logic signed [DATA_W-1:0] MIN_V = 16'sh8000;

	logic                    clk;
	logic                    rst;
	logic                    sample_valid;
	logic signed [DATA_W-1:0] j0;
	logic signed [DATA_W-1:0] j1;
	logic signed [DATA_W-1:0] j2;
	logic signed [DATA_W-1:0] r;
	logic                    result_valid;
	logic signed [ACC_W-1:0] result_lanes [N_LANES];
	logic                    frame_open;

	int                      errors = 0;
	int                      cycle = 0; // rising edges seen so far.
	int                      frames_checked = 0;
	int                      seed;
	int                      taken = 0; // samples accepted in the open frame.
	longint                  sums [N_LANES];
	logic signed [ACC_W-1:0] exp_q [$]; // nine sums per finished frame.
	int                      edge_q [$]; // accepting edge of each last sample.
	logic signed [ACC_W-1:0] held [N_LANES];

	gn_normal_top u_gn_normal_top (
		.clk          (clk),
		.rst          (rst),
		.sample_valid (sample_valid),
		.j0           (j0),
		.j1           (j1),
		.j2           (j2),
		.r            (r),
		.result_valid (result_valid),
		.result_lanes (result_lanes),
		.frame_open   (frame_open)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d results pending", cycle, edge_q.size());
			$display("Done: errors found");
			$finish;
		end
	end

	// ****************************************
	// result monitor
	// ****************************************
	always @(negedge clk) begin
		logic signed [ACC_W-1:0] want;
		lane_e                   ln;
		int                      due;
		if (!rst) begin
			if (result_valid) begin
				assert (edge_q.size() > 0) else begin
					errors++;
					$display("result_valid pulsed at cycle %0d with no frame pending", cycle);
				end
				if (edge_q.size() > 0) begin
					due = edge_q.pop_front() + LATENCY;
					assert (cycle == due) else begin
						errors++;
						$display("result_valid came at cycle %0d instead of cycle %0d", cycle, due);
					end
					for (int i = 0; i < N_LANES; i++) begin
						want = exp_q.pop_front();
						ln = lane_e'(i);
						assert (result_lanes[i] === want) else begin
							errors++;
							$display("[FAIL] result_lanes[%s] got %h expected %h",
								ln.name(), result_lanes[i], want);
						end
						held[i] = want; // next frame must not disturb it.
					end
					frames_checked++;
				end
			end else begin
				for (int i = 0; i < N_LANES; i++) begin
					ln = lane_e'(i);
					assert (result_lanes[i] === held[i]) else begin
						errors++;
						$display("[FAIL] result_lanes[%s] got %h expected held %h",
							ln.name(), result_lanes[i], held[i]);
					end
				end
			end
		end
	end

	// ****************************************
	// stimulus and model
	// ****************************************
	// one call per cycle; frame_open is checked against samples already accepted
	task automatic drive_sample(input logic valid, input logic signed [DATA_W-1:0] a0,
		input logic signed [DATA_W-1:0] a1, input logic signed [DATA_W-1:0] a2,
		input logic signed [DATA_W-1:0] res);
		@(posedge clk);
		#1;
		assert (frame_open === (taken != 0)) else begin
			errors++;
			$display("[FAIL] frame_open got %h expected %h", frame_open, taken != 0);
		end
		sample_valid = valid;
		j0 = a0;
		j1 = a1;
		j2 = a2;
		r = res;
		if (valid) begin
			if (taken == 0) begin
				foreach (sums[i]) sums[i] = 0; // new frame.
			end
			sums[ln_j00] += longint'(a0) * longint'(a0);
			sums[ln_j01] += longint'(a0) * longint'(a1);
			sums[ln_j02] += longint'(a0) * longint'(a2);
			sums[ln_j11] += longint'(a1) * longint'(a1);
			sums[ln_j12] += longint'(a1) * longint'(a2);
			sums[ln_j22] += longint'(a2) * longint'(a2);
			sums[ln_r0] += longint'(a0) * longint'(res);
			sums[ln_r1] += longint'(a1) * longint'(res);
			sums[ln_r2] += longint'(a2) * longint'(res);
			taken++;
			if (taken == FRAME_LEN) begin
				for (int i = 0; i < N_LANES; i++) begin
					exp_q.push_back(ACC_W'(sums[i]));
				end
				edge_q.push_back(cycle + 1); // accepted at the next edge.
				taken = 0;
			end
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_sample(1'b0, '0, '0, '0, '0);
	endtask

	function automatic logic signed [DATA_W-1:0] rand_data();
		return DATA_W'($random(seed));
	endfunction

	// ****************************************
	// tests
	// ****************************************
	task automatic check_reset();
		lane_e ln;
		@(negedge clk);
		assert (result_valid === 1'b0) else begin
			errors++;
			$display("[FAIL] result_valid got %h expected 0", result_valid);
		end
		assert (frame_open === 1'b0) else begin
			errors++;
			$display("[FAIL] frame_open got %h expected 0", frame_open);
		end
		for (int i = 0; i < N_LANES; i++) begin
			ln = lane_e'(i);
			assert (result_lanes[i] === '0) else begin
				errors++;
				$display("[FAIL] result_lanes[%s] got %h expected 0", ln.name(), result_lanes[i]);
			end
		end
	endtask

	task automatic known_frame();
		for (int i = 0; i < FRAME_LEN; i++) begin
			drive_sample(1'b1, DATA_W'(i + 1), DATA_W'(2 - i), DATA_W'(3 * i - 7),
				DATA_W'(5 - 2 * i));
		end
		idle_cycles(8); // pulse and its single cycle seen by the monitor.
	endtask

	task automatic back_to_back(input int n);
		repeat (n * FRAME_LEN) drive_sample(1'b1, rand_data(), rand_data(), rand_data(),
			rand_data());
		idle_cycles(8);
	endtask

	task automatic gapped_frames(input int n);
		int gap;
		repeat (n * FRAME_LEN) begin
			gap = $random(seed) & 3; // 0 to 3 bubbles.
			idle_cycles(gap);
			drive_sample(1'b1, rand_data(), rand_data(), rand_data(), rand_data());
		end
		idle_cycles(8);
	endtask

	task automatic extreme_frames();
		repeat (FRAME_LEN) drive_sample(1'b1, MIN_V, MIN_V, MIN_V, MIN_V);
		idle_cycles(20); // results must hold through idle time.
		for (int i = 0; i < FRAME_LEN; i++) begin
			drive_sample(1'b1, (i % 2 == 1) ? MIN_V : MAX_V, MIN_V, MAX_V,
				(i % 2 == 1) ? MAX_V : MIN_V);
		end
		idle_cycles(20);
	endtask

	initial begin
		seed = 79116;
		rst = 1'b1;
		sample_valid = 1'b0;
		j0 = '0;
		j1 = '0;
		j2 = '0;
		r = '0;
		foreach (held[i]) held[i] = '0;
		foreach (sums[i]) sums[i] = 0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		check_reset();
		known_frame();
		back_to_back(4);
		gapped_frames(2);
		extreme_frames();
		while (edge_q.size() > 0) @(posedge clk);
		$display("errors: %0d, frames checked: %0d of %0d", errors, frames_checked, N_FRAMES);
		if (errors == 0 && frames_checked == N_FRAMES) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== build.f ====
gn_num_pkg.sv
gn_ctrl_pkg.sv
prod_ifc.sv
lane_mult.sv
lane_accum.sv
frame_seq.sv
gn_normal_top.sv
tb_gn_normal.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the normal-equation builder and its testbench with Verilator, then run it.
# Exit status is nonzero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_gn_normal -o sim_gn_normal
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_gn_normal > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	exit 1
fi
exit 0
